//--- all.f
ecc_pkg.sv
mem_pkg.sv
secded_enc.sv
secded_dec.sv
sram_bank.sv
ecc_scrubber.sv
ecc_sram_wrap.sv
tb_ecc_sram.sv
tb_ecc_sram_sva.sv

//--- ecc_pkg.sv
// SECDED code geometry for the protected SRAM bank
// Extended Hamming (39,32): 32 data bits, six check bits, one overall parity bit

package ecc_pkg;

  localparam int unsigned DataWidth      = 32;
  localparam int unsigned CheckWidth     = 7;  // Six Hamming bits plus overall parity
  localparam int unsigned ProtectedWidth = DataWidth + CheckWidth;
  localparam int unsigned HammingWidth   = CheckWidth - 1;

  // Codeword layout
  //   [31:0]  data
  //   [37:32] check bits, check bit i is the XOR of the data bits in mask i
  //   [38]    overall parity over bits 37..0
  //
  // Each data bit has a distinct column of mask membership. The columns are
  // all 20 weight-three patterns, all six weight-five patterns and six
  // weight-four patterns. None is a single-bit pattern, so a check-bit error
  // never aliases onto a data bit.
  localparam logic [HammingWidth-1:0][DataWidth-1:0] CheckMasks = {
    32'hDBEF_FC00,  // Mask 5
    32'hBBDF_03F0,  // Mask 4
    32'hD7B8_E38E,  // Mask 3
    32'h3774_9A6D,  // Mask 2
    32'h6EF2_555B,  // Mask 1
    32'hEDF1_2CB7   // Mask 0
  };

  // Error flag encoding
  localparam int unsigned ErrWidth       = 2;
  localparam int unsigned err_single_bit = 0;  // Corrected, data is good
  localparam int unsigned err_multi_bit  = 1;  // Uncorrectable

endpackage

//--- ecc_scrubber.sv
// Background ECC scrubber
// Uses idle bank cycles to read each word and writes back single-error fixes
// Bus traffic always wins and passes straight to the bank

`timescale 1ns/10ps

module ecc_scrubber #(
  parameter  int unsigned BankSize  = mem_pkg::DefaultBankSize,
  localparam int unsigned AddrWidth = $clog2(BankSize)
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               scrub_trigger_i,
  output logic                               bit_corrected_o,

  input  logic                               intc_req_i,
  input  logic                               intc_we_i,
  input  logic [AddrWidth-1:0]               intc_addr_i,
  input  logic [ecc_pkg::ProtectedWidth-1:0] intc_wdata_i,
  output logic [ecc_pkg::ProtectedWidth-1:0] intc_rdata_o,

  output logic                               bank_req_o,
  output logic                               bank_we_o,
  output logic [AddrWidth-1:0]               bank_addr_o,
  output logic [ecc_pkg::ProtectedWidth-1:0] bank_wdata_o,
  input  logic [ecc_pkg::ProtectedWidth-1:0] bank_rdata_i
);

  import ecc_pkg::*;

  typedef enum logic [1:0] {
    ScrubIdle,
    ScrubRead,  // Waiting for a free bank cycle to read
    ScrubFix    // Decoding the word read last cycle
  } scrub_state_e;

  scrub_state_e state_d, state_q;

  logic [AddrWidth-1:0]      addr_d, addr_q;
  logic                      scrub_req;
  logic                      scrub_we;
  logic [DataWidth-1:0]      fixed_data;
  logic [ProtectedWidth-1:0] fixed_code;
  logic [ErrWidth-1:0]       err;

  secded_dec i_dec (
    .code_i     (bank_rdata_i),
    .data_o     (fixed_data),
    .syndrome_o (),
    .err_o      (err)
  );

  secded_enc i_enc (
    .data_i (fixed_data),
    .code_o (fixed_code)
  );

  always_comb begin : proc_scrub_fsm
    state_d         = state_q;
    addr_d          = addr_q;
    scrub_req       = 1'b0;
    scrub_we        = 1'b0;
    bit_corrected_o = 1'b0;
    case (state_q)
      ScrubIdle: begin
        if (scrub_trigger_i) begin
          state_d = ScrubRead;
        end
      end
      ScrubRead: begin
        if (!scrub_trigger_i) begin
          state_d = ScrubIdle;
        end else if (!intc_req_i) begin
          scrub_req = 1'b1;
          state_d   = ScrubFix;
        end
      end
      ScrubFix: begin
        state_d = scrub_trigger_i ? ScrubRead : ScrubIdle;
        if (err[err_single_bit]) begin
          // Busy bus means the fix is dropped and the word read again
          if (!intc_req_i) begin
            scrub_req       = 1'b1;
            scrub_we        = 1'b1;
            bit_corrected_o = 1'b1;
            addr_d          = addr_q + 1'b1;
          end
        end else begin
          addr_d = addr_q + 1'b1;  // Clean, or beyond repair
        end
      end
      default: state_d = ScrubIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_scrub_ff
    if (!rst_ni) begin
      state_q <= ScrubIdle;
      addr_q  <= '0;
    end else begin
      state_q <= state_d;
      addr_q  <= addr_d;  // Wraps at BankSize
    end
  end

  assign bank_req_o   = intc_req_i | scrub_req;
  assign bank_we_o    = intc_req_i ? intc_we_i : scrub_we;
  assign bank_addr_o  = intc_req_i ? intc_addr_i : addr_q;
  assign bank_wdata_o = scrub_we ? fixed_code : intc_wdata_i;
  assign intc_rdata_o = bank_rdata_i;

endmodule

//--- ecc_sram_wrap.sv
// SECDED-protected SRAM bank on a 32-bit word bus
// Partial stores run as read-modify-write with one cycle of low grant
// Loads return corrected data with single and multi error flags

`timescale 1ns/10ps

module ecc_sram_wrap #(
  parameter  int unsigned BankSize      = mem_pkg::DefaultBankSize,
  localparam int unsigned BankAddrWidth = $clog2(BankSize)
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,

  input  logic                               scrub_trigger_i,  // Low keeps scrubber off
  output logic                               scrubber_fix_o,

  input  logic                               req_i,
  input  logic                               we_i,
  input  logic [mem_pkg::BusAddrWidth-1:0]   addr_i,
  input  logic [ecc_pkg::DataWidth-1:0]      wdata_i,
  input  logic [mem_pkg::BeWidth-1:0]        be_i,
  input  logic [ecc_pkg::ProtectedWidth-1:0] test_write_mask_ni,  // Low bits get written
  output logic                               gnt_o,
  output logic [ecc_pkg::DataWidth-1:0]      rdata_o,
  output logic                               single_error_o,
  output logic                               multi_error_o
);

  import ecc_pkg::*;
  import mem_pkg::*;

  typedef enum logic {
    StNormal,
    StMerge  // Second half of a partial store
  } rmw_state_e;

  rmw_state_e state_d, state_q;

  logic                     full_word;
  logic                     rmw_start;
  logic [BankAddrWidth-1:0] word_addr;
  logic [BankAddrWidth-1:0] addr_q;
  logic [DataWidth-1:0]     wdata_q;
  logic [BeWidth-1:0]       be_q;
  logic [DataWidth-1:0]     be_mask;
  logic [DataWidth-1:0]     loaded;
  logic [DataWidth-1:0]     to_store;
  logic                     valid_read_d, valid_read_q;
  logic [ErrWidth-1:0]      ecc_err;

  logic                      intc_req, intc_we;
  logic [BankAddrWidth-1:0]  intc_addr;
  logic [ProtectedWidth-1:0] intc_wdata, intc_rdata;

  logic                      bank_req, bank_we;
  logic [BankAddrWidth-1:0]  bank_addr;
  logic [ProtectedWidth-1:0] bank_wdata, bank_rdata;

  assign word_addr = addr_i[BankAddrWidth+WordOffset-1:WordOffset];
  assign full_word = &be_i;
  assign rmw_start = req_i && we_i && !full_word && (state_q == StNormal);

  always_comb begin : proc_be_mask
    for (int b = 0; b < BeWidth; b++) begin
      be_mask[b*ByteWidth +: ByteWidth] = {ByteWidth{be_q[b]}};
    end
  end

  always_comb begin : proc_rmw_fsm
    state_d   = rmw_start ? StMerge : StNormal;
    gnt_o     = 1'b1;
    intc_req  = req_i;
    intc_we   = we_i && full_word;  // Partial store reads first
    intc_addr = word_addr;
    to_store  = wdata_i;
    if (state_q == StMerge) begin
      gnt_o     = 1'b0;
      intc_req  = 1'b1;
      intc_we   = 1'b1;
      intc_addr = addr_q;
      to_store  = (be_mask & wdata_q) | (~be_mask & loaded);
    end
  end

  // Loads and the read half of partial stores
  assign valid_read_d = req_i && gnt_o && !(we_i && full_word);

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_ctrl_ff
    if (!rst_ni) begin
      state_q      <= StNormal;
      valid_read_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      valid_read_q <= valid_read_d;
    end
  end

  always_ff @(posedge clk_i) begin : proc_buf_ff
    if (rmw_start) begin
      addr_q  <= word_addr;
      wdata_q <= wdata_i;
      be_q    <= be_i;
    end
  end

  secded_dec i_dec (
    .code_i     (intc_rdata),
    .data_o     (loaded),
    .syndrome_o (),
    .err_o      (ecc_err)
  );

  secded_enc i_enc (
    .data_i (to_store),
    .code_o (intc_wdata)
  );

  assign rdata_o        = loaded;
  assign single_error_o = ecc_err[err_single_bit] && valid_read_q;
  assign multi_error_o  = ecc_err[err_multi_bit] && valid_read_q;

  ecc_scrubber #(
    .BankSize (BankSize)
  ) i_scrubber (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .scrub_trigger_i (scrub_trigger_i),
    .bit_corrected_o (scrubber_fix_o),
    .intc_req_i      (intc_req),
    .intc_we_i       (intc_we),
    .intc_addr_i     (intc_addr),
    .intc_wdata_i    (intc_wdata),
    .intc_rdata_o    (intc_rdata),
    .bank_req_o      (bank_req),
    .bank_we_o       (bank_we),
    .bank_addr_o     (bank_addr),
    .bank_wdata_o    (bank_wdata),
    .bank_rdata_i    (bank_rdata)
  );

  sram_bank #(
    .BankSize (BankSize)
  ) i_bank (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (bank_req),
    .we_i     (bank_we),
    .addr_i   (bank_addr),
    .wdata_i  (bank_wdata),
    .bit_en_i (~test_write_mask_ni),
    .rdata_o  (bank_rdata)
  );

endmodule

//--- mem_pkg.sv
// Bus and bank constants for the ECC SRAM wrapper
// Byte-addressed 32-bit word bus, word-addressed bank

package mem_pkg;

  localparam int unsigned ByteWidth       = 8;
  localparam int unsigned BeWidth         = 4;   // One enable per byte lane
  localparam int unsigned BusAddrWidth    = 32;  // Byte address on the bus

  // Byte offset bits dropped to get the word address
  localparam int unsigned WordOffset      = $clog2(BeWidth);

  localparam int unsigned DefaultBankSize = 256;  // Words

endpackage

//--- run.sh
#!/bin/sh
# Build the ECC SRAM testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ecc_sram -f all.f -o tb_ecc_sram

./obj_dir/tb_ecc_sram 2>&1 | tee sim.log

if grep -q "Finished with no errors" sim.log; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

//--- secded_dec.sv
// SECDED decoder
// Corrects any single-bit error and flags double-bit errors

`timescale 1ns/10ps

module secded_dec (
  input  logic [ecc_pkg::ProtectedWidth-1:0] code_i,
  output logic [ecc_pkg::DataWidth-1:0]      data_o,
  output logic [ecc_pkg::CheckWidth-1:0]     syndrome_o,
  output logic [ecc_pkg::ErrWidth-1:0]       err_o
);

  import ecc_pkg::*;

  logic [CheckWidth-1:0] syndrome;
  logic                  parity_fail;
  logic                  check_fail;

  always_comb begin : proc_syndrome
    for (int i = 0; i < HammingWidth; i++) begin
      syndrome[i] = ^(code_i[DataWidth-1:0] & CheckMasks[i]) ^ code_i[DataWidth+i];
    end
    syndrome[CheckWidth-1] = ^code_i;  // Whole word parity, zero when intact
  end

  assign parity_fail = syndrome[CheckWidth-1];
  assign check_fail  = |syndrome[HammingWidth-1:0];

  // Odd number of flips is taken as one. A parity-only error has a zero
  // check syndrome and also lands here.
  assign err_o[err_single_bit] = parity_fail;
  assign err_o[err_multi_bit]  = check_fail && !parity_fail;

  always_comb begin : proc_correct
    logic [HammingWidth-1:0] column;
    data_o = code_i[DataWidth-1:0];
    for (int j = 0; j < DataWidth; j++) begin
      for (int i = 0; i < HammingWidth; i++) begin
        column[i] = CheckMasks[i][j];
      end
      // Check-bit errors match no data column and leave the data alone
      if (parity_fail && (column == syndrome[HammingWidth-1:0])) begin
        data_o[j] = ~code_i[j];
      end
    end
  end

  assign syndrome_o = syndrome;

endmodule

//--- secded_enc.sv
// SECDED encoder
// Builds a 39-bit codeword from 32 data bits

`timescale 1ns/10ps

module secded_enc (
  input  logic [ecc_pkg::DataWidth-1:0]      data_i,
  output logic [ecc_pkg::ProtectedWidth-1:0] code_o
);

  import ecc_pkg::*;

  logic [HammingWidth-1:0] checks;
  logic                    parity;

  always_comb begin : proc_checks
    for (int i = 0; i < HammingWidth; i++) begin
      checks[i] = ^(data_i & CheckMasks[i]);
    end
  end

  // Overall parity covers data and check bits
  assign parity = ^{checks, data_i};

  assign code_o = {parity, checks, data_i};

endmodule

//--- sram_bank.sv
// Single-port SRAM bank for 39-bit codewords
// One-cycle read latency, per-bit write enable, contents start at zero

`timescale 1ns/10ps

module sram_bank #(
  parameter  int unsigned BankSize  = mem_pkg::DefaultBankSize,
  localparam int unsigned AddrWidth = $clog2(BankSize)
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               req_i,
  input  logic                               we_i,
  input  logic [AddrWidth-1:0]               addr_i,
  input  logic [ecc_pkg::ProtectedWidth-1:0] wdata_i,
  input  logic [ecc_pkg::ProtectedWidth-1:0] bit_en_i,
  output logic [ecc_pkg::ProtectedWidth-1:0] rdata_o
);

  import ecc_pkg::*;

  // All-zero is a valid codeword, so a fresh bank decodes clean
  logic [ProtectedWidth-1:0] mem_q [BankSize] = '{default: '0};

  always_ff @(posedge clk_i) begin : proc_write
    if (req_i && we_i) begin
      mem_q[addr_i] <= (wdata_i & bit_en_i) | (mem_q[addr_i] & ~bit_en_i);
    end
  end

  // Read data holds until the next read
  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_read
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (req_i && !we_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

//--- tb_ecc_sram.sv
// Testbench for the SECDED-protected SRAM bank
// Random full and partial stores, error injection through the write mask, scrubbing

`timescale 1ns/10ps

module tb_ecc_sram;

  import ecc_pkg::*;
  import mem_pkg::*;

  localparam int unsigned BankSize    = 16;
  localparam int unsigned AddrBits    = $clog2(BankSize);
  localparam int unsigned ClkPeriod   = 4;
  localparam int unsigned ResetCycles = 4;
  localparam int unsigned InjectCount = 4;
  localparam int unsigned ScrubLimit  = 3 * BankSize;
  // Cycles of all tests together including the scrub wait
  localparam int unsigned TestCycles  = ResetCycles + 9 * BankSize + 10 * InjectCount + 16;

  typedef struct packed {
    logic                 check_data;  // Low for loads whose data is not predictable
    logic [DataWidth-1:0] data;
    logic                 single;
    logic                 multi;
  } expect_t;

  logic clk_i, rst_ni;
  logic scrub_trigger_i, scrubber_fix_o;
  logic req_i, we_i, gnt_o;
  logic [BusAddrWidth-1:0]   addr_i;
  logic [DataWidth-1:0]      wdata_i, rdata_o;
  logic [BeWidth-1:0]        be_i;
  logic [ProtectedWidth-1:0] test_write_mask_ni;
  logic single_error_o, multi_error_o;

  logic [31:0]          lfsr_q;
  logic [DataWidth-1:0] shadow [BankSize];  // Expected data per word
  expect_t              expect_q [$];
  int unsigned          errors, checks;

  ecc_sram_wrap #(
    .BankSize (BankSize)
  ) dut (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .scrub_trigger_i    (scrub_trigger_i),
    .scrubber_fix_o     (scrubber_fix_o),
    .req_i              (req_i),
    .we_i               (we_i),
    .addr_i             (addr_i),
    .wdata_i            (wdata_i),
    .be_i               (be_i),
    .test_write_mask_ni (test_write_mask_ni),
    .gnt_o              (gnt_o),
    .rdata_o            (rdata_o),
    .single_error_o     (single_error_o),
    .multi_error_o      (multi_error_o)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin : watchdog
    #((TestCycles + ScrubLimit) * ClkPeriod);
    $display("Timeout: the tests did not complete within %0d cycles", TestCycles + ScrubLimit);
    $display("Finished with errors");
    $finish;
  end

  function automatic logic [31:0] next_lfsr(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32, 22, 2, 1
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = next_lfsr(lfsr_q);
      bits   = {bits[30:0], lfsr_q[0]};
    end
  endtask

  // Expected codeword from data, six mask parities and parity over all of it
  function automatic logic [ProtectedWidth-1:0] encode_ref(input logic [DataWidth-1:0] d);
    logic [ProtectedWidth-2:0] body;
    body[DataWidth-1:0] = d;
    for (int i = 0; i < HammingWidth; i++) begin
      body[DataWidth+i] = ^(d & CheckMasks[i]);
    end
    return {^body, body};
  endfunction

  // Drives one request and returns 1 ns after the edge that accepts it
  task automatic issue_request(input logic we, input logic [AddrBits-1:0] widx,
                               input logic [DataWidth-1:0] data, input logic [BeWidth-1:0] be,
                               input logic [ProtectedWidth-1:0] mask);
    logic granted;
    req_i              = 1'b1;
    we_i               = we;
    addr_i             = BusAddrWidth'(widx) << WordOffset;
    wdata_i            = data;
    be_i               = be;
    test_write_mask_ni = mask;
    do begin
      @(negedge clk_i);
      granted = gnt_o;
      @(posedge clk_i);
    end while (!granted);
    #1;
  endtask

  task automatic store_word(input logic [AddrBits-1:0] widx, input logic [DataWidth-1:0] data,
                            input logic [ProtectedWidth-1:0] mask);
    issue_request(1'b1, widx, data, '1, mask);
    req_i              = 1'b0;
    test_write_mask_ni = '0;
  endtask

  task automatic load_word(input logic [AddrBits-1:0] widx, input logic check_data,
                           input logic single, input logic multi);
    issue_request(1'b0, widx, '0, '0, '0);
    expect_q.push_back(expect_t'{check_data, shadow[widx], single, multi});
    req_i = 1'b0;
  endtask

  task automatic merge_store(input logic [AddrBits-1:0] widx, input logic [DataWidth-1:0] data,
                             input logic [BeWidth-1:0] be);
    issue_request(1'b1, widx, data, be, '0);
    expect_q.push_back(expect_t'{1'b0, '0, 1'b0, 1'b0});  // Flags of the read half
    for (int b = 0; b < BeWidth; b++) begin
      if (be[b]) shadow[widx][b*ByteWidth +: ByteWidth] = data[b*ByteWidth +: ByteWidth];
    end
    @(negedge clk_i);
    checks++;
    if (gnt_o) begin
      errors++;
      $display("mismatch at %0t: gnt_o high in the cycle after a partial write to word %0d",
               $time, widx);
    end
    @(posedge clk_i);
    #1;
    req_i = 1'b0;
    @(negedge clk_i);
    checks++;
    if (!gnt_o) begin
      errors++;
      $display("mismatch at %0t: gnt_o low two cycles after a partial write to word %0d",
               $time, widx);
    end
    @(posedge clk_i);
    #1;
  endtask

  // Writes A, then B with differing codeword bits masked, so those bits keep A's value
  task automatic inject_flips(input int nbits, input logic [AddrBits-1:0] widx,
                              output logic [DataWidth-1:0] data_b);
    logic [DataWidth-1:0]      data_a;
    logic [31:0]               pick;
    logic [ProtectedWidth-1:0] diff, mask;
    int                        k, found;
    rand_bits(32, data_a);
    do begin
      rand_bits(32, data_b);
    end while (data_b == data_a);
    diff = encode_ref(data_a) ^ encode_ref(data_b);
    rand_bits(6, pick);
    k     = pick % ProtectedWidth;
    mask  = '0;
    found = 0;
    while (found < nbits) begin
      if (diff[k] && !mask[k]) begin
        mask[k] = 1'b1;
        found++;
      end
      k = (k + 1) % ProtectedWidth;
    end
    store_word(widx, data_a, '0);
    store_word(widx, data_b, mask);
    shadow[widx] = data_b;
  endtask

  task automatic report_test(input string name, input int unsigned start_errors);
    do begin
      @(posedge clk_i);
      #1;
    end while (expect_q.size() != 0);
    $display("Test %s done with %0d errors", name, errors - start_errors);
  endtask

  always @(negedge clk_i) begin : compare
    expect_t exp_e;
    if (expect_q.size() != 0) begin
      exp_e = expect_q.pop_front();
      checks++;
      if (exp_e.check_data && (rdata_o !== exp_e.data)) begin
        errors++;
        $display("mismatch at %0t: rdata_o %h, expected %h", $time, rdata_o, exp_e.data);
      end
      if ((single_error_o !== exp_e.single) || (multi_error_o !== exp_e.multi)) begin
        errors++;
        $display("mismatch at %0t: single %b multi %b, expected %b %b", $time,
                 single_error_o, multi_error_o, exp_e.single, exp_e.multi);
      end
    end
  end

  initial begin : stimulus
    logic [31:0]          rnd;
    logic [DataWidth-1:0] data;
    logic [AddrBits-1:0]  addr_a, addr_b;
    int unsigned          fixes, waited, test_start;
    lfsr_q             = 32'h6e46;
    errors             = 0;
    checks             = 0;
    rst_ni             = 1'b0;
    scrub_trigger_i    = 1'b0;
    req_i              = 1'b0;
    we_i               = 1'b0;
    addr_i             = '0;
    wdata_i            = '0;
    be_i               = '0;
    test_write_mask_ni = '0;
    repeat (ResetCycles) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    test_start = errors;
    for (int w = 0; w < BankSize; w++) begin
      rand_bits(32, data);
      store_word(AddrBits'(w), data, '0);
      shadow[w] = data;
    end
    for (int w = 0; w < BankSize; w++) load_word(AddrBits'(w), 1'b1, 1'b0, 1'b0);
    report_test("full writes", test_start);

    test_start = errors;
    for (int w = 0; w < BankSize; w++) begin
      rand_bits(32, data);
      do begin
        rand_bits(BeWidth, rnd);
      end while ((rnd[3:0] == 4'h0) || (rnd[3:0] == 4'hf));
      merge_store(AddrBits'(w), data, rnd[BeWidth-1:0]);
    end
    for (int w = 0; w < BankSize; w++) load_word(AddrBits'(w), 1'b1, 1'b0, 1'b0);
    report_test("partial writes", test_start);

    test_start = errors;
    for (int n = 0; n < InjectCount; n++) begin
      rand_bits(AddrBits, rnd);
      inject_flips(1, rnd[AddrBits-1:0], data);
      load_word(rnd[AddrBits-1:0], 1'b1, 1'b1, 1'b0);
      store_word(rnd[AddrBits-1:0], data, '0);  // Clean copy for the scrub test
    end
    report_test("single errors", test_start);

    test_start = errors;
    for (int n = 0; n < InjectCount; n++) begin
      rand_bits(AddrBits, rnd);
      inject_flips(2, rnd[AddrBits-1:0], data);
      load_word(rnd[AddrBits-1:0], 1'b0, 1'b0, 1'b1);
      store_word(rnd[AddrBits-1:0], data, '0);
    end
    report_test("double errors", test_start);

    test_start = errors;
    rand_bits(AddrBits, rnd);
    addr_a = rnd[AddrBits-1:0];
    rand_bits(AddrBits, rnd);
    addr_b = AddrBits'(addr_a + 1 + (rnd % (BankSize - 1)));  // Never equal to addr_a
    inject_flips(1, addr_a, data);
    inject_flips(1, addr_b, data);
    scrub_trigger_i = 1'b1;
    fixes  = 0;
    waited = 0;
    while ((fixes < 2) && (waited < ScrubLimit)) begin
      @(negedge clk_i);
      if (scrubber_fix_o) fixes++;
      waited++;
    end
    @(posedge clk_i);
    #1;
    scrub_trigger_i = 1'b0;
    checks++;
    if (fixes != 2) begin
      errors++;
      $display("Scrubber repaired %0d of 2 words within %0d cycles", fixes, ScrubLimit);
    end
    load_word(addr_a, 1'b1, 1'b0, 1'b0);
    load_word(addr_b, 1'b1, 1'b0, 1'b0);
    report_test("scrubbing", test_start);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- tb_ecc_sram_sva.sv
// Assertions on the ECC SRAM wrapper
// Grant back-pressure, error flag exclusivity and scrubber bus priority

`timescale 1ns/10ps

module tb_ecc_sram_sva (
  input logic                        clk_i,
  input logic                        rst_ni,
  input logic                        req_i,
  input logic                        we_i,
  input logic [mem_pkg::BeWidth-1:0] be_i,
  input logic                        gnt_i,
  input logic                        single_error_i,
  input logic                        multi_error_i,
  input logic                        scrub_fix_i
);

  logic rmw_accept;

  assign rmw_accept = req_i && gnt_i && we_i && !(&be_i);  // Partial write taken

  gnt_low_after_rmw: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !gnt_i |-> $past(rmw_accept)
  ) else $error("grant low without a partial write accepted the cycle before");

  rmw_drops_gnt: assert property (
    @(posedge clk_i) disable iff (!rst_ni) rmw_accept |=> !gnt_i
  ) else $error("grant stayed high after an accepted partial write");

  flags_exclusive: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(single_error_i && multi_error_i)
  ) else $error("single and multi error flags high together");

  fix_while_idle: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(scrub_fix_i && req_i)
  ) else $error("scrubber fix while the bus requests");

endmodule

bind ecc_sram_wrap tb_ecc_sram_sva i_sva (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .req_i          (req_i),
  .we_i           (we_i),
  .be_i           (be_i),
  .gnt_i          (gnt_o),
  .single_error_i (single_error_o),
  .multi_error_i  (multi_error_o),
  .scrub_fix_i    (scrubber_fix_o)
);
